//--- common/vic_defs.svh
`ifndef VIC_DEFS_SVH
`define VIC_DEFS_SVH

// Display mode codes, formed as {ecm, bmm, mcm}
`define MODE_STANDARD_CHAR      3'b000
`define MODE_MULTICOLOR_CHAR    3'b001
`define MODE_STANDARD_BITMAP    3'b010
`define MODE_MULTICOLOR_BITMAP  3'b011
`define MODE_EXTENDED_BG_COLOR  3'b100
`define MODE_INV_ECM_MC_CHAR    3'b101
`define MODE_INV_ECM_BITMAP     3'b110
`define MODE_INV_ECM_MC_BITMAP  3'b111

// Palette index shown by the invalid modes
`define BLACK 4'd0

// Character cycles in which graphics data is shown
`define VISIBLE_FIRST 7'd15
`define VISIBLE_LAST  7'd54

`define LINE_CYCLES 7'd63

`endif

//--- common/vic_pkg.sv
package vic_pkg;

    // 4-bit palette index
    typedef logic [3:0] color_t;

    // Fetched character word
    // Bits 11..8 hold the color nibble, bits 7..0 the screen code
    typedef logic [11:0] char_word_t;

    // Pixel value handed from the shifter to the color stage
    // The top three bits form the display mode code
    typedef struct packed {
        logic       ecm;
        logic       bmm;
        logic       mcm;
        logic [1:0] code;
    } pixel_value_t;

    // Blank pixel value, standard character mode with code 00
    localparam pixel_value_t PIXEL_VALUE_NONE = '{
        ecm:  1'b0,
        bmm:  1'b0,
        mcm:  1'b0,
        code: 2'b00
    };

endpackage

//--- design/delay_line.sv
`timescale 1ns/10ps

module delay_line #(
    parameter type         payload_t = logic [7:0],
    parameter int unsigned DEPTH     = 2
) (
    input  logic     clk_dot4x,
    input  logic     rst_i,
    input  logic     shift_i,
    input  payload_t data_i,
    output payload_t data_o
);

    payload_t chain_q [DEPTH];

    always_ff @(posedge clk_dot4x) begin
        if (rst_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                chain_q[i] <= '0;
            end
        end else if (shift_i) begin
            chain_q[0] <= data_i;
            // Older entries move one step toward the output
            for (int i = 1; i < DEPTH; i++) begin
                chain_q[i] <= chain_q[i-1];
            end
        end
    end

    assign data_o = chain_q[DEPTH-1];

endmodule

//--- design/dot_timing.sv
`timescale 1ns/10ps

`include "vic_defs.svh"

module dot_timing (
    input  logic       clk_dot4x,
    input  logic       rst_i,
    output logic [3:0] dot_rising_o,
    output logic [2:0] cycle_bit_o,
    output logic [6:0] cycle_num_o,
    output logic       fetch_strobe_o
);

    logic [1:0] phase_q;

    always_ff @(posedge clk_dot4x) begin
        if (rst_i) begin
            phase_q     <= 2'd0;
            cycle_bit_o <= 3'd0;
            cycle_num_o <= 7'd0;
        end else begin
            phase_q <= phase_q + 2'd1;
            // Last dot phase of a pixel
            if (dot_rising_o[3]) begin
                cycle_bit_o <= cycle_bit_o + 3'd1;
                if (cycle_bit_o == 3'd7) begin
                    if (cycle_num_o == `LINE_CYCLES - 7'd1) begin
                        cycle_num_o <= 7'd0;
                    end else begin
                        cycle_num_o <= cycle_num_o + 7'd1;
                    end
                end
            end
        end
    end

    assign dot_rising_o = 4'b0001 << phase_q;

    // One pulse per character cycle, at the start of pixel 0
    assign fetch_strobe_o = dot_rising_o[0] && (cycle_bit_o == 3'd0);

endmodule

//--- sequencer/pixel_shifter.sv
`timescale 1ns/10ps

`include "vic_defs.svh"

module pixel_shifter (
    input  logic                 clk_dot4x,
    input  logic                 rst_i,
    input  logic [3:0]           dot_rising_i,
    input  logic [2:0]           cycle_bit_i,
    input  logic [6:0]           cycle_num_i,
    input  logic                 fetch_strobe_i,
    input  logic                 mcm_i,
    input  logic                 bmm_i,
    input  logic                 ecm_i,
    input  logic                 idle_i,
    input  logic                 vborder_i,
    input  logic [2:0]           xscroll_i,
    input  logic [7:0]           pixels_read_i,
    input  vic_pkg::char_word_t  char_read_i,
    output vic_pkg::pixel_value_t pixel_value_o,
    output vic_pkg::char_word_t  char_word_o,
    output logic                 background_o,
    output logic                 stage0_o
);

    import vic_pkg::*;

    logic [7:0]   pixels_d, pixels_q, pixels_n;
    char_word_t   char_d, char_n;
    logic [2:0]   xscroll_q;
    logic         mcm_q, mcm_prev_q, bmm_q, ecm_q, mc_ff_q;
    logic         mcm_n, mcm_prev_n, bmm_n, ecm_n, mc_ff_n;
    logic         visible, load, bg_n;
    pixel_value_t pv_n;

    // Fetched data reaches the shifter two character cycles later
    delay_line #(.payload_t(logic [7:0]), .DEPTH(2)) u_pixels_delay (
        .clk_dot4x (clk_dot4x),
        .rst_i     (rst_i),
        .shift_i   (fetch_strobe_i),
        .data_i    (pixels_read_i),
        .data_o    (pixels_d)
    );

    delay_line #(.payload_t(char_word_t), .DEPTH(2)) u_char_delay (
        .clk_dot4x (clk_dot4x),
        .rst_i     (rst_i),
        .shift_i   (fetch_strobe_i),
        .data_i    (char_read_i),
        .data_o    (char_d)
    );

    assign visible = (cycle_num_i >= `VISIBLE_FIRST) && (cycle_num_i <= `VISIBLE_LAST);
    assign load    = (xscroll_q == cycle_bit_i);

    always_comb begin
        mcm_n      = mcm_q;
        mcm_prev_n = mcm_prev_q;
        bmm_n      = bmm_q;
        ecm_n      = ecm_q;
        mc_ff_n    = mc_ff_q;
        pixels_n   = pixels_q;
        char_n     = char_word_o;
        // Mode bits settle over pixels 4 to 7, as on the real chip
        if (cycle_bit_i == 3'd4) begin
            mcm_n = mcm_i;
            bmm_n = bmm_q | bmm_i;
            ecm_n = ecm_q | ecm_i;
        end else if (cycle_bit_i == 3'd6) begin
            bmm_n = bmm_q & bmm_i;
            ecm_n = ecm_q & ecm_i;
        end else if (cycle_bit_i == 3'd7) begin
            if (mcm_q && !mcm_prev_q) begin
                mc_ff_n = 1'b0;
            end
            mcm_prev_n = mcm_q;
        end
        if (load) begin
            mc_ff_n = 1'b1;
            if (visible && !vborder_i) begin
                pixels_n = pixels_d;
                char_n   = idle_i ? char_word_t'(0) : char_d;
            end else begin
                pixels_n = 8'h00;
            end
        end
        pv_n = '{ecm: ecm_n, bmm: bmm_n, mcm: mcm_n, code: pixel_value_o.code};
        bg_n = !pixels_n[7];
        if (mcm_prev_n && (bmm_n || char_n[11])) begin
            // Multicolor pairs are taken only every second pixel
            if (mc_ff_n) begin
                pv_n.code = pixels_n[7:6];
            end else begin
                bg_n = background_o;
            end
        end else if (!mcm_prev_n && (bmm_n || char_n[11])) begin
            pv_n.code = {pixels_n[7], 1'b0};
        end else begin
            pv_n.code = {2{pixels_n[7]}};
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst_i) begin
            mcm_q      <= 1'b0;
            mcm_prev_q <= 1'b0;
            bmm_q      <= 1'b0;
            ecm_q      <= 1'b0;
            mc_ff_q    <= 1'b0;
            xscroll_q  <= 3'd0;
            stage0_o   <= 1'b0;
        end else begin
            stage0_o <= dot_rising_i[1];
            if (fetch_strobe_i && visible && !vborder_i) begin
                xscroll_q <= xscroll_i;
            end
            if (dot_rising_i[1]) begin
                mcm_q      <= mcm_n;
                mcm_prev_q <= mcm_prev_n;
                bmm_q      <= bmm_n;
                ecm_q      <= ecm_n;
                mc_ff_q    <= mc_ff_n;
            end else if (dot_rising_i[3]) begin
                mc_ff_q <= ~mc_ff_q;
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (dot_rising_i[1]) begin
            pixels_q      <= {pixels_n[6:0], 1'b0};
            char_word_o   <= char_n;
            pixel_value_o <= pv_n;
            background_o  <= bg_n;
        end
    end

endmodule

//--- sequencer/color_resolver.sv
`timescale 1ns/10ps

`include "vic_defs.svh"

module color_resolver (
    input  logic                  clk_dot4x,
    input  logic                  rst_i,
    input  logic                  stage0_i,
    input  vic_pkg::pixel_value_t pixel_value_i,
    input  vic_pkg::char_word_t   char_word_i,
    input  logic                  background_i,
    input  vic_pkg::color_t       b0c_i,
    input  vic_pkg::color_t       b1c_i,
    input  vic_pkg::color_t       b2c_i,
    input  vic_pkg::color_t       b3c_i,
    input  vic_pkg::color_t       ec_i,
    output vic_pkg::color_t       color_o,
    output vic_pkg::color_t       ec_o,
    output logic                  background_o,
    output logic                  stage1_o
);

    import vic_pkg::*;

    color_t b0c_q, b1c_q, b2c_q, b3c_q;
    color_t color_n;

    always_comb begin
        case ({pixel_value_i.ecm, pixel_value_i.bmm, pixel_value_i.mcm})
            `MODE_STANDARD_CHAR:
                color_n = pixel_value_i.code[1] ? char_word_i[11:8] : b0c_q;
            `MODE_MULTICOLOR_CHAR: begin
                // Only chars with color bit 3 set are multicolor
                if (char_word_i[11]) begin
                    case (pixel_value_i.code)
                        2'b00:   color_n = b0c_q;
                        2'b01:   color_n = b1c_q;
                        2'b10:   color_n = b2c_q;
                        default: color_n = {1'b0, char_word_i[10:8]};
                    endcase
                end else begin
                    color_n = pixel_value_i.code[1] ? {1'b0, char_word_i[10:8]} : b0c_q;
                end
            end
            `MODE_STANDARD_BITMAP:
                color_n = pixel_value_i.code[1] ? char_word_i[7:4] : char_word_i[3:0];
            `MODE_MULTICOLOR_BITMAP: begin
                case (pixel_value_i.code)
                    2'b00:   color_n = b0c_q;
                    2'b01:   color_n = char_word_i[7:4];
                    2'b10:   color_n = char_word_i[3:0];
                    default: color_n = char_word_i[11:8];
                endcase
            end
            `MODE_EXTENDED_BG_COLOR: begin
                // Top two screen code bits pick the background register
                case ({pixel_value_i.code[1], char_word_i[7:6]})
                    3'b000:  color_n = b0c_q;
                    3'b001:  color_n = b1c_q;
                    3'b010:  color_n = b2c_q;
                    3'b011:  color_n = b3c_q;
                    default: color_n = char_word_i[11:8];
                endcase
            end
            default:
                color_n = `BLACK;
        endcase
    end

    always_ff @(posedge clk_dot4x) begin
        if (stage0_i) begin
            b0c_q        <= b0c_i;
            b1c_q        <= b1c_i;
            b2c_q        <= b2c_i;
            b3c_q        <= b3c_i;
            ec_o         <= ec_i;
            color_o      <= color_n;
            background_o <= background_i;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst_i) begin
            stage1_o <= 1'b0;
        end else begin
            stage1_o <= stage0_i;
        end
    end

endmodule

//--- sequencer/sprite_mixer.sv
`timescale 1ns/10ps

module sprite_mixer (
    input  logic            clk_dot4x,
    input  logic            rst_i,
    input  logic [3:0]      dot_rising_i,
    input  logic            stage1_i,
    input  vic_pkg::color_t color_i,
    input  vic_pkg::color_t ec_i,
    input  logic            background_i,
    input  logic            main_border_i,
    input  logic            sprite_active_i,
    input  logic            sprite_pri_i,
    input  logic            sprite_mmc_i,
    input  logic [1:0]      sprite_pixel_i,
    input  vic_pkg::color_t sprite_col_i,
    input  vic_pkg::color_t sprite_mc0_i,
    input  vic_pkg::color_t sprite_mc1_i,
    output vic_pkg::color_t pixel_color_o,
    output logic            pixel_strobe_o
);

    import vic_pkg::*;

    color_t sprite_col_d, sprite_mc0_d, sprite_mc1_d;
    color_t overlay_color;
    logic   border_q;

    // Sprite color writes take effect two pixels late
    delay_line #(.payload_t(color_t), .DEPTH(2)) u_col_delay (
        .clk_dot4x (clk_dot4x),
        .rst_i     (rst_i),
        .shift_i   (dot_rising_i[1]),
        .data_i    (sprite_col_i),
        .data_o    (sprite_col_d)
    );

    delay_line #(.payload_t(color_t), .DEPTH(2)) u_mc0_delay (
        .clk_dot4x (clk_dot4x),
        .rst_i     (rst_i),
        .shift_i   (dot_rising_i[1]),
        .data_i    (sprite_mc0_i),
        .data_o    (sprite_mc0_d)
    );

    delay_line #(.payload_t(color_t), .DEPTH(2)) u_mc1_delay (
        .clk_dot4x (clk_dot4x),
        .rst_i     (rst_i),
        .shift_i   (dot_rising_i[1]),
        .data_i    (sprite_mc1_i),
        .data_o    (sprite_mc1_d)
    );

    always_comb begin
        overlay_color = color_i;
        // Behind-foreground sprites only show over background pixels
        if (sprite_active_i && (!sprite_pri_i || background_i)) begin
            if (sprite_mmc_i) begin
                case (sprite_pixel_i)
                    2'b01:   overlay_color = sprite_mc0_d;
                    2'b10:   overlay_color = sprite_col_d;
                    2'b11:   overlay_color = sprite_mc1_d;
                    default: overlay_color = color_i;
                endcase
            end else if (sprite_pixel_i[1]) begin
                overlay_color = sprite_col_d;
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst_i) begin
            border_q       <= 1'b0;
            pixel_strobe_o <= 1'b0;
        end else begin
            pixel_strobe_o <= stage1_i;
            if (dot_rising_i[1]) begin
                border_q <= main_border_i;
            end
        end
    end

    // Border mask wins over graphics and sprites
    always_ff @(posedge clk_dot4x) begin
        if (stage1_i) begin
            pixel_color_o <= border_q ? ec_i : overlay_color;
        end
    end

endmodule

//--- design/pixel_sequencer_top.sv
`timescale 1ns/10ps

module pixel_sequencer_top (
    input  logic                clk_dot4x,
    input  logic                rst_i,
    input  logic                mcm_i,
    input  logic                bmm_i,
    input  logic                ecm_i,
    input  logic                idle_i,
    input  logic                vborder_i,
    input  logic [2:0]          xscroll_i,
    input  logic [7:0]          pixels_read_i,
    input  vic_pkg::char_word_t char_read_i,
    input  vic_pkg::color_t     b0c_i,
    input  vic_pkg::color_t     b1c_i,
    input  vic_pkg::color_t     b2c_i,
    input  vic_pkg::color_t     b3c_i,
    input  vic_pkg::color_t     ec_i,
    input  logic                main_border_i,
    input  logic                sprite_active_i,
    input  logic                sprite_pri_i,
    input  logic                sprite_mmc_i,
    input  logic [1:0]          sprite_pixel_i,
    input  vic_pkg::color_t     sprite_col_i,
    input  vic_pkg::color_t     sprite_mc0_i,
    input  vic_pkg::color_t     sprite_mc1_i,
    output vic_pkg::color_t     pixel_color_o,
    output logic                pixel_strobe_o,
    output logic [2:0]          cycle_bit_o,
    output logic [6:0]          cycle_num_o
);

    import vic_pkg::*;

    logic [3:0]   dot_rising;
    logic         fetch_strobe;
    pixel_value_t pixel_value;
    char_word_t   char_word;
    logic         background0, background1;
    logic         stage0, stage1;
    color_t       color1, ec1;

    dot_timing u_dot_timing (
        .clk_dot4x      (clk_dot4x),
        .rst_i          (rst_i),
        .dot_rising_o   (dot_rising),
        .cycle_bit_o    (cycle_bit_o),
        .cycle_num_o    (cycle_num_o),
        .fetch_strobe_o (fetch_strobe)
    );

    pixel_shifter u_pixel_shifter (
        .clk_dot4x      (clk_dot4x),
        .rst_i          (rst_i),
        .dot_rising_i   (dot_rising),
        .cycle_bit_i    (cycle_bit_o),
        .cycle_num_i    (cycle_num_o),
        .fetch_strobe_i (fetch_strobe),
        .mcm_i          (mcm_i),
        .bmm_i          (bmm_i),
        .ecm_i          (ecm_i),
        .idle_i         (idle_i),
        .vborder_i      (vborder_i),
        .xscroll_i      (xscroll_i),
        .pixels_read_i  (pixels_read_i),
        .char_read_i    (char_read_i),
        .pixel_value_o  (pixel_value),
        .char_word_o    (char_word),
        .background_o   (background0),
        .stage0_o       (stage0)
    );

    color_resolver u_color_resolver (
        .clk_dot4x     (clk_dot4x),
        .rst_i         (rst_i),
        .stage0_i      (stage0),
        .pixel_value_i (pixel_value),
        .char_word_i   (char_word),
        .background_i  (background0),
        .b0c_i         (b0c_i),
        .b1c_i         (b1c_i),
        .b2c_i         (b2c_i),
        .b3c_i         (b3c_i),
        .ec_i          (ec_i),
        .color_o       (color1),
        .ec_o          (ec1),
        .background_o  (background1),
        .stage1_o      (stage1)
    );

    sprite_mixer u_sprite_mixer (
        .clk_dot4x       (clk_dot4x),
        .rst_i           (rst_i),
        .dot_rising_i    (dot_rising),
        .stage1_i        (stage1),
        .color_i         (color1),
        .ec_i            (ec1),
        .background_i    (background1),
        .main_border_i   (main_border_i),
        .sprite_active_i (sprite_active_i),
        .sprite_pri_i    (sprite_pri_i),
        .sprite_mmc_i    (sprite_mmc_i),
        .sprite_pixel_i  (sprite_pixel_i),
        .sprite_col_i    (sprite_col_i),
        .sprite_mc0_i    (sprite_mc0_i),
        .sprite_mc1_i    (sprite_mc1_i),
        .pixel_color_o   (pixel_color_o),
        .pixel_strobe_o  (pixel_strobe_o)
    );

endmodule

//--- testbench/tb_pixel_sequencer.sv
`timescale 1ns/10ps

`include "vic_defs.svh"

module tb_pixel_sequencer;

    import vic_pkg::*;

    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 10;
    localparam int LINE_CLOCKS     = int'(`LINE_CYCLES) * 8 * 4;
    // Four character cycles, so the fetch delay, mode bits and color samples settle
    localparam int SETTLE_CLOCKS   = 4 * 8 * 4;
    localparam int PIXELS_PER_TEST = 64;
    localparam int NUM_TESTS       = 30;
    localparam int WATCHDOG_NS     = (NUM_TESTS * 4 * LINE_CLOCKS + RESET_CYCLES) * CLK_PERIOD;

    logic       clk_dot4x = 1'b0;
    logic       rst;
    logic       mcm, bmm, ecm, idle, vborder;
    logic [2:0] xscroll;
    logic [7:0] pixels;
    char_word_t char_word;
    color_t     b0c, b1c, b2c, b3c, ec;
    logic       main_border;
    logic       sprite_active, sprite_pri, sprite_mmc;
    logic [1:0] sprite_pixel;
    color_t     sprite_col, sprite_mc0, sprite_mc1;
    color_t     pixel_color;
    logic       pixel_strobe;
    logic [2:0] cycle_bit;
    logic [6:0] cycle_num;

    integer      seed = 32'hc12b5d17;
    logic        check_en;
    logic        pixel_check;
    int unsigned clock_count = 0;
    color_t      expected_color;
    string       test_name;
    int          check_total = 0;
    int          error_total = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    always #(CLK_PERIOD / 2) clk_dot4x = ~clk_dot4x;

    pixel_sequencer_top UUT (
        .clk_dot4x       (clk_dot4x),
        .rst_i           (rst),
        .mcm_i           (mcm),
        .bmm_i           (bmm),
        .ecm_i           (ecm),
        .idle_i          (idle),
        .vborder_i       (vborder),
        .xscroll_i       (xscroll),
        .pixels_read_i   (pixels),
        .char_read_i     (char_word),
        .b0c_i           (b0c),
        .b1c_i           (b1c),
        .b2c_i           (b2c),
        .b3c_i           (b3c),
        .ec_i            (ec),
        .main_border_i   (main_border),
        .sprite_active_i (sprite_active),
        .sprite_pri_i    (sprite_pri),
        .sprite_mmc_i    (sprite_mmc),
        .sprite_pixel_i  (sprite_pixel),
        .sprite_col_i    (sprite_col),
        .sprite_mc0_i    (sprite_mc0),
        .sprite_mc1_i    (sprite_mc1),
        .pixel_color_o   (pixel_color),
        .pixel_strobe_o  (pixel_strobe),
        .cycle_bit_o     (cycle_bit),
        .cycle_num_o     (cycle_num)
    );

    // Graphics color for a fill pattern whose pixel pairs are all equal
    function automatic color_t graphics_color();
        char_word_t cw;
        color_t     gfx;
        cw = idle ? char_word_t'(0) : char_word;
        case ({ecm, bmm, mcm})
            `MODE_STANDARD_CHAR:
                gfx = pixels[7] ? cw[11:8] : b0c;
            `MODE_MULTICOLOR_CHAR: begin
                if (!cw[11]) begin
                    gfx = pixels[7] ? {1'b0, cw[10:8]} : b0c;
                end else begin
                    case (pixels[7:6])
                        2'b00:   gfx = b0c;
                        2'b01:   gfx = b1c;
                        2'b10:   gfx = b2c;
                        default: gfx = {1'b0, cw[10:8]};
                    endcase
                end
            end
            `MODE_STANDARD_BITMAP:
                gfx = pixels[7] ? cw[7:4] : cw[3:0];
            `MODE_MULTICOLOR_BITMAP: begin
                case (pixels[7:6])
                    2'b00:   gfx = b0c;
                    2'b01:   gfx = cw[7:4];
                    2'b10:   gfx = cw[3:0];
                    default: gfx = cw[11:8];
                endcase
            end
            `MODE_EXTENDED_BG_COLOR: begin
                if (pixels[7]) begin
                    gfx = cw[11:8];
                end else begin
                    case (cw[7:6])
                        2'b00:   gfx = b0c;
                        2'b01:   gfx = b1c;
                        2'b10:   gfx = b2c;
                        default: gfx = b3c;
                    endcase
                end
            end
            default:
                gfx = `BLACK;
        endcase
        return gfx;
    endfunction

    function automatic color_t reference_color();
        color_t c;
        c = graphics_color();
        // Leading bit clear means a background pixel for every pattern used here
        if (sprite_active && (!sprite_pri || !pixels[7])) begin
            if (sprite_mmc) begin
                case (sprite_pixel)
                    2'b01:   c = sprite_mc0;
                    2'b10:   c = sprite_col;
                    2'b11:   c = sprite_mc1;
                    default: begin
                    end
                endcase
            end else if (sprite_pixel[1]) begin
                c = sprite_col;
            end
        end
        if (main_border) begin
            c = ec;
        end
        return c;
    endfunction

    // Clocks since reset, the reference for the pixel and character counters
    always @(posedge clk_dot4x) begin
        if (rst) begin
            clock_count <= 0;
        end else begin
            clock_count <= clock_count + 1;
        end
    end

    assign pixel_check = check_en && pixel_strobe &&
                         cycle_num > `VISIBLE_FIRST && cycle_num <= `VISIBLE_LAST;

    always @(posedge clk_dot4x) begin
        if (pixel_check) begin
            check_total++;
        end
    end

    // Pre-edge values, so strobe and color belong to the same pixel
    assert property (@(posedge clk_dot4x) pixel_check |-> pixel_color == expected_color)
    else begin
        error_total++;
        $display("error: pixel_color_o = 0x%h, expected 0x%h (%s, cycle %0d bit %0d)",
                 $sampled(pixel_color), expected_color, test_name,
                 $sampled(cycle_num), $sampled(cycle_bit));
    end

    // Pixel index steps every four clocks
    assert property (@(posedge clk_dot4x) disable iff (rst)
                     cycle_bit == 3'(clock_count / 4))
    else begin
        error_total++;
        $display("error: cycle_bit_o = 0x%h, expected 0x%h",
                 $sampled(cycle_bit), 3'($sampled(clock_count) / 4));
    end

    // Character cycle steps every eight pixels and wraps at the line end
    assert property (@(posedge clk_dot4x) disable iff (rst)
                     cycle_num == 7'((clock_count / 32) % `LINE_CYCLES))
    else begin
        error_total++;
        $display("error: cycle_num_o = 0x%h, expected 0x%h",
                 $sampled(cycle_num), 7'(($sampled(clock_count) / 32) % `LINE_CYCLES));
    end

    task automatic randomize_inputs();
        logic [31:0] r;
        r = $random(seed);
        {b0c, b1c, b2c, b3c, ec, sprite_col, sprite_mc0, sprite_mc1} = r;
        r = $random(seed);
        char_word     = r[11:0];
        xscroll       = r[14:12];
        {ecm, bmm, mcm} = `MODE_STANDARD_CHAR;
        pixels        = 8'h00;
        idle          = 1'b0;
        vborder       = 1'b0;
        main_border   = 1'b0;
        sprite_active = 1'b0;
        sprite_pri    = 1'b0;
        sprite_mmc    = 1'b0;
        sprite_pixel  = 2'b00;
    endtask

    task automatic run_check(input string name);
        int start_checks;
        int start_errors;
        expected_color = reference_color();
        test_name      = name;
        start_checks   = check_total;
        start_errors   = error_total;
        repeat (SETTLE_CLOCKS) @(negedge clk_dot4x);
        check_en = 1'b1;
        while (check_total - start_checks < PIXELS_PER_TEST) begin
            @(negedge clk_dot4x);
        end
        check_en = 1'b0;
        tests_run++;
        if (error_total == start_errors) begin
            $display("test %0d %s: passed, %0d pixels", tests_run, name,
                     check_total - start_checks);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name,
                     error_total - start_errors);
        end
    endtask

    task automatic graphics_case(input string name, input logic [2:0] mode,
                                 input logic [7:0] pattern,
                                 input logic [11:0] char_mask,
                                 input logic [11:0] char_value);
        randomize_inputs();
        {ecm, bmm, mcm} = mode;
        pixels    = pattern;
        char_word = (char_word & ~char_mask) | char_value;
        run_check(name);
    endtask

    task automatic sprite_case(input string name, input logic [7:0] pattern,
                               input logic pri, input logic mmc, input logic [1:0] code);
        randomize_inputs();
        pixels        = pattern;
        sprite_active = 1'b1;
        sprite_pri    = pri;
        sprite_mmc    = mmc;
        sprite_pixel  = code;
        run_check(name);
    endtask

    initial begin
        logic [7:0]  pattern;
        logic [31:0] r;
        rst      = 1'b1;
        check_en = 1'b0;
        randomize_inputs();
        repeat (RESET_CYCLES) @(negedge clk_dot4x);
        rst = 1'b0;

        graphics_case("standard char, ones", `MODE_STANDARD_CHAR, 8'hff, 12'h000, 12'h000);
        graphics_case("standard char, zeros", `MODE_STANDARD_CHAR, 8'h00, 12'h000, 12'h000);
        randomize_inputs();
        idle          = 1'b1;
        // Idle forces character 0 and its one pixels then match a black b0c
        pixels        = 8'hff;
        b0c           = `BLACK;
        char_word[11] = 1'b1;
        run_check("standard char, idle");

        for (int p = 0; p < 4; p++) begin
            pattern = {4{p[1:0]}};
            graphics_case($sformatf("multicolor char, pattern %h", pattern),
                          `MODE_MULTICOLOR_CHAR, pattern, 12'h800, 12'h800);
        end
        // Color bit 3 clear keeps the character hires
        for (int p = 0; p < 2; p++) begin
            pattern = {8{p[0]}};
            graphics_case($sformatf("multicolor char hires, pattern %h", pattern),
                          `MODE_MULTICOLOR_CHAR, pattern, 12'h800, 12'h000);
        end
        for (int p = 0; p < 2; p++) begin
            pattern = {8{p[0]}};
            graphics_case($sformatf("standard bitmap, pattern %h", pattern),
                          `MODE_STANDARD_BITMAP, pattern, 12'h000, 12'h000);
        end
        for (int p = 0; p < 4; p++) begin
            pattern = {4{p[1:0]}};
            graphics_case($sformatf("multicolor bitmap, pattern %h", pattern),
                          `MODE_MULTICOLOR_BITMAP, pattern, 12'h000, 12'h000);
        end
        for (int p = 0; p < 4; p++) begin
            graphics_case($sformatf("extended background %0d", p),
                          `MODE_EXTENDED_BG_COLOR, 8'h00, 12'h0c0, {4'h0, p[1:0], 6'h00});
        end
        for (int p = 5; p < 8; p++) begin
            graphics_case($sformatf("invalid mode %0d", p), p[2:0], 8'hff, 12'h000, 12'h000);
        end

        sprite_case("hires sprite, foreground", 8'hff, 1'b0, 1'b0, 2'b10);
        sprite_case("hires sprite behind, zero pixels", 8'h00, 1'b1, 1'b0, 2'b10);
        sprite_case("hires sprite behind, one pixels", 8'hff, 1'b1, 1'b0, 2'b10);
        sprite_case("multicolor sprite, code 01", 8'hff, 1'b0, 1'b1, 2'b01);
        sprite_case("multicolor sprite, code 11", 8'hff, 1'b0, 1'b1, 2'b11);
        sprite_case("multicolor sprite, code 00", 8'hff, 1'b0, 1'b1, 2'b00);

        // Border hides any mode and sprite
        for (int p = 0; p < 2; p++) begin
            randomize_inputs();
            r = $random(seed);
            {ecm, bmm, mcm} = r[2:0];
            pixels        = r[15:8];
            sprite_active = r[16];
            sprite_pri    = r[17];
            sprite_mmc    = r[18];
            sprite_pixel  = r[20:19];
            main_border   = 1'b1;
            run_check($sformatf("border, mode %0d", r[2:0]));
        end

        $display("tests %0d, failed %0d, pixels checked %0d, errors %0d",
                 tests_run, tests_failed, check_total, error_total);
        if (tests_failed == 0 && error_total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- all.f
+incdir+common
common/vic_pkg.sv
design/delay_line.sv
design/dot_timing.sv
sequencer/pixel_shifter.sv
sequencer/color_resolver.sv
sequencer/sprite_mixer.sv
design/pixel_sequencer_top.sv
testbench/tb_pixel_sequencer.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_pixel_sequencer
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF -- "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
